/* fwrisc_state_unit.f */
+incdir+rtl
rtl/fwrisc_pkg.sv
rtl/csr_addr_map.sv
rtl/fwrisc_regfile.sv
rtl/trap_guard.sv
rtl/fwrisc_state_unit.sv
verification/tb_fwrisc_state_unit.sv

/* rtl/csr_addr_map.sv */
// Purely combinational; only machine-mode CSRs and the custom numbers 0x7C0 to 0x7C2 are known
module csr_addr_map (
	input  fwrisc_pkg::rd_req_t  rb_req,
	input  fwrisc_pkg::wr_req_t  wr_req,
	output fwrisc_pkg::csr_idx_e rb_idx,
	output fwrisc_pkg::csr_idx_e wr_idx,
	output logic                 wr_en,
	output logic                 csr_illegal
);

	logic rb_unmapped;
	logic wr_unmapped;

	// Same decode for both request paths
	function automatic fwrisc_pkg::csr_idx_e map_idx(
		input logic        is_csr,
		input logic [11:0] num
	);
		fwrisc_pkg::csr_idx_e idx;
		if (!is_csr) begin
			// General register index passes straight through
			idx = fwrisc_pkg::csr_idx_e'({1'b0, num[4:0]});
		end else begin
			case (num)
				12'hf11: idx = fwrisc_pkg::IDX_MVENDORID;
				12'hf12: idx = fwrisc_pkg::IDX_MARCHID;
				12'hf13: idx = fwrisc_pkg::IDX_MIMPID;
				12'hf14: idx = fwrisc_pkg::IDX_MHARTID;
				12'h300: idx = fwrisc_pkg::IDX_MSTATUS;
				12'h301: idx = fwrisc_pkg::IDX_MISA;
				12'h304: idx = fwrisc_pkg::IDX_MIE;
				12'h305: idx = fwrisc_pkg::IDX_MTVEC;
				12'h340: idx = fwrisc_pkg::IDX_MSCRATCH;
				12'h344: idx = fwrisc_pkg::IDX_MIP;
				12'hb00: idx = fwrisc_pkg::IDX_MCYCLE;
				12'hb80: idx = fwrisc_pkg::IDX_MCYCLEH;
				12'hb02: idx = fwrisc_pkg::IDX_MINSTRET;
				12'hb82: idx = fwrisc_pkg::IDX_MINSTRETH;
				// Custom machine read/write space
				12'h7c0: idx = fwrisc_pkg::IDX_DEP_LO;
				12'h7c1: idx = fwrisc_pkg::IDX_DEP_HI;
				12'h7c2: idx = fwrisc_pkg::IDX_SOFT_RESET;
				default: idx = fwrisc_pkg::IDX_NONE;
			endcase
		end
		return idx;
	endfunction

	assign rb_idx = map_idx(rb_req.is_csr, rb_req.num);
	assign wr_idx = map_idx(wr_req.is_csr, wr_req.num);

	assign rb_unmapped = rb_req.is_csr && (rb_idx == fwrisc_pkg::IDX_NONE);
	assign wr_unmapped = wr_req.wen && wr_req.is_csr && (wr_idx == fwrisc_pkg::IDX_NONE);

	// Unknown writes never reach the register file
	assign wr_en = wr_req.wen && (wr_idx != fwrisc_pkg::IDX_NONE);

	assign csr_illegal = rb_unmapped || wr_unmapped;

endmodule

/* rtl/fwrisc_defines.svh */
// Identity CSR values are fixed at build time and DEP can only be removed here, not at run time
`ifndef FWRISC_DEFINES_SVH
`define FWRISC_DEFINES_SVH

// Read-only identity CSRs
`define FWRISC_VENDORID 32'h0000_0000
`define FWRISC_ARCHID   32'h0000_0000
`define FWRISC_IMPID    32'h0000_0001
`define FWRISC_HARTID   32'h0000_0000

// Extension bits of misa, top two bits (MXL) are added by the register file
`define FWRISC_ISA      30'h0000_0100

// Data-execution-protection bounds
// 0 makes both bounds read as zero and suppresses every fault
`define FWRISC_ENABLE_DEP 1

// Internal register index width
// 0..31 general registers, CSRs above
`define FWRISC_IDX_W    6

`endif

/* rtl/fwrisc_pkg.sv */
// Index values 0 to 31 are reserved for the general registers and must stay below bit 5
`include "fwrisc_defines.svh"

package fwrisc_pkg;

	// Internal register index shared by the mapper and the register file
	typedef enum logic [`FWRISC_IDX_W-1:0] {
		IDX_X0         = 6'd0,
		IDX_MVENDORID  = 6'd32,
		IDX_MARCHID    = 6'd33,
		IDX_MIMPID     = 6'd34,
		IDX_MHARTID    = 6'd35,
		IDX_MISA       = 6'd36,
		IDX_MSTATUS    = 6'd37,
		IDX_MIE        = 6'd38,
		IDX_MTVEC      = 6'd39,
		IDX_MSCRATCH   = 6'd40,
		IDX_MIP        = 6'd41,
		IDX_MCYCLE     = 6'd42,
		IDX_MCYCLEH    = 6'd43,
		IDX_MINSTRET   = 6'd44,
		IDX_MINSTRETH  = 6'd45,
		IDX_DEP_LO     = 6'd46,
		IDX_DEP_HI     = 6'd47,
		IDX_SOFT_RESET = 6'd48,
		IDX_NONE       = 6'd63
	} csr_idx_e;

	// Read request, num[4:0] is the register when is_csr is low
	typedef struct packed {
		logic        is_csr;
		logic [11:0] num;
	} rd_req_t;

	typedef struct packed {
		logic        wen;
		logic        is_csr;
		logic [11:0] num;
		logic [31:0] wdata;
	} wr_req_t;

	// Pulses from the pipeline, irq is a level
	typedef struct packed {
		logic instr_complete;
		logic trap;
		logic tret;
		logic irq;
	} core_event_t;

	typedef struct packed {
		logic [31:0] dep_lo;
		logic [31:0] dep_hi;
	} prot_bounds_t;

endpackage

/* rtl/fwrisc_regfile.sv */
// Both read ports have one cycle of latency and return the pre-write value; only port b sees CSRs
`include "fwrisc_defines.svh"

module fwrisc_regfile (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [4:0]               ra_raddr,
	input  fwrisc_pkg::csr_idx_e     rb_idx,
	input  fwrisc_pkg::csr_idx_e     wr_idx,
	input  logic                     wr_en,
	input  logic [31:0]              wdata,
	input  fwrisc_pkg::core_event_t  events,
	output logic [31:0]              ra_rdata,
	output logic [31:0]              rb_rdata,
	output fwrisc_pkg::prot_bounds_t bounds,
	output logic [31:0]              mtvec,
	output logic                     mie,
	output logic                     meie,
	output logic                     soft_reset_req
);

	localparam logic [31:0] misa_val = {2'b01, `FWRISC_ISA};

	logic [31:0] regs [0:31];
	logic [63:0] cycle_count;
	logic [63:0] instr_count;
	logic [31:0] dep_lo_r;
	logic [31:0] dep_hi_r;
	logic [31:0] mtvec_r;
	logic [31:0] mscratch;
	logic        mpie;
	logic        gpr_we;

	// Write strobe for one CSR index
	function automatic logic wr_hit(input fwrisc_pkg::csr_idx_e idx);
		return wr_en && (wr_idx == idx);
	endfunction

	// x0 is never written
	assign gpr_we = wr_en && !wr_idx[5] && (wr_idx != fwrisc_pkg::IDX_X0);

	assign bounds.dep_lo = (`FWRISC_ENABLE_DEP != 0) ? dep_lo_r : 32'd0;
	assign bounds.dep_hi = (`FWRISC_ENABLE_DEP != 0) ? dep_hi_r : 32'd0;
	assign mtvec = mtvec_r;

	assign soft_reset_req = wr_hit(fwrisc_pkg::IDX_SOFT_RESET);

	always_ff @(posedge clock) begin
		if (reset) begin
			cycle_count <= 64'd0;
			instr_count <= 64'd0;
			dep_lo_r    <= 32'd0;
			dep_hi_r    <= 32'd0;
			mtvec_r     <= 32'd0;
			mscratch    <= 32'd0;
			meie        <= 1'b1;
			mie         <= 1'b1;
			mpie        <= 1'b0;
		end else begin
			// A half write replaces the increment for that cycle
			if (wr_hit(fwrisc_pkg::IDX_MCYCLE)) begin
				cycle_count <= {cycle_count[63:32], wdata};
			end else if (wr_hit(fwrisc_pkg::IDX_MCYCLEH)) begin
				cycle_count <= {wdata, cycle_count[31:0]};
			end else begin
				cycle_count <= cycle_count + 64'd1;
			end

			if (wr_hit(fwrisc_pkg::IDX_MINSTRET)) begin
				instr_count <= {instr_count[63:32], wdata};
			end else if (wr_hit(fwrisc_pkg::IDX_MINSTRETH)) begin
				instr_count <= {wdata, instr_count[31:0]};
			end else if (events.instr_complete) begin
				instr_count <= instr_count + 64'd1;
			end

			// Interrupt enable stack
			if (events.trap) begin
				mpie <= mie;
				mie  <= 1'b0;
			end
			if (events.tret) begin
				mie  <= mpie;
				mpie <= 1'b0;
			end
			// Software write to mstatus wins over trap and tret
			if (wr_hit(fwrisc_pkg::IDX_MSTATUS)) begin
				mie  <= wdata[3];
				mpie <= wdata[7];
			end

			if (wr_hit(fwrisc_pkg::IDX_MIE)) begin
				meie <= wdata[11];
			end
			if (wr_hit(fwrisc_pkg::IDX_MTVEC)) begin
				mtvec_r <= wdata;
			end
			if (wr_hit(fwrisc_pkg::IDX_MSCRATCH)) begin
				mscratch <= wdata;
			end

			// Bit 1 locks each bound until the next reset
			if (wr_hit(fwrisc_pkg::IDX_DEP_LO) && !dep_lo_r[1]) begin
				dep_lo_r <= wdata;
			end
			if (wr_hit(fwrisc_pkg::IDX_DEP_HI) && !dep_hi_r[1]) begin
				dep_hi_r <= wdata;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (gpr_we) begin
			regs[wr_idx[4:0]] <= wdata;
		end
	end

	// Read ports
	always_ff @(posedge clock) begin
		ra_rdata <= (ra_raddr == 5'd0) ? 32'd0 : regs[ra_raddr];

		case (rb_idx)
			fwrisc_pkg::IDX_MVENDORID: rb_rdata <= `FWRISC_VENDORID;
			fwrisc_pkg::IDX_MARCHID:   rb_rdata <= `FWRISC_ARCHID;
			fwrisc_pkg::IDX_MIMPID:    rb_rdata <= `FWRISC_IMPID;
			fwrisc_pkg::IDX_MHARTID:   rb_rdata <= `FWRISC_HARTID;
			fwrisc_pkg::IDX_MISA:      rb_rdata <= misa_val;
			fwrisc_pkg::IDX_MSTATUS:   rb_rdata <= {24'd0, mpie, 3'd0, mie, 3'd0};
			fwrisc_pkg::IDX_MIE:       rb_rdata <= {20'd0, meie, 11'd0};
			fwrisc_pkg::IDX_MTVEC:     rb_rdata <= mtvec_r;
			fwrisc_pkg::IDX_MSCRATCH:  rb_rdata <= mscratch;
			fwrisc_pkg::IDX_MIP:       rb_rdata <= {20'd0, events.irq, 11'd0};
			fwrisc_pkg::IDX_MCYCLE:    rb_rdata <= cycle_count[31:0];
			fwrisc_pkg::IDX_MCYCLEH:   rb_rdata <= cycle_count[63:32];
			fwrisc_pkg::IDX_MINSTRET:  rb_rdata <= instr_count[31:0];
			fwrisc_pkg::IDX_MINSTRETH: rb_rdata <= instr_count[63:32];
			fwrisc_pkg::IDX_DEP_LO:    rb_rdata <= bounds.dep_lo;
			fwrisc_pkg::IDX_DEP_HI:    rb_rdata <= bounds.dep_hi;
			default: begin
				// General registers, x0, soft reset and unmapped all land here
				if (!rb_idx[5] && (rb_idx != fwrisc_pkg::IDX_X0)) begin
					rb_rdata <= regs[rb_idx[4:0]];
				end else begin
					rb_rdata <= 32'd0;
				end
			end
		endcase
	end

endmodule

/* rtl/fwrisc_state_unit.sv */
// No back-pressure; every read, write and event is taken in the cycle it is presented
module fwrisc_state_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [4:0]              ra_raddr,
	input  fwrisc_pkg::rd_req_t     rb_req,
	input  fwrisc_pkg::wr_req_t     wr_req,
	input  fwrisc_pkg::core_event_t events,
	input  logic [31:0]             fetch_addr,
	output logic [31:0]             ra_rdata,
	output logic [31:0]             rb_rdata,
	output logic                    csr_illegal,
	output logic [31:0]             mtvec,
	output logic                    irq_pending,
	output logic                    dep_fault,
	output logic                    soft_reset_req
);

	fwrisc_pkg::csr_idx_e     rb_idx;
	fwrisc_pkg::csr_idx_e     wr_idx;
	logic                     wr_en;
	fwrisc_pkg::prot_bounds_t bounds;
	logic                     mie;
	logic                     meie;

	csr_addr_map u_csr_addr_map (
		.rb_req      (rb_req),
		.wr_req      (wr_req),
		.rb_idx      (rb_idx),
		.wr_idx      (wr_idx),
		.wr_en       (wr_en),
		.csr_illegal (csr_illegal)
	);

	fwrisc_regfile u_fwrisc_regfile (
		.clock          (clock),
		.reset          (reset),
		.ra_raddr       (ra_raddr),
		.rb_idx         (rb_idx),
		.wr_idx         (wr_idx),
		.wr_en          (wr_en),
		.wdata          (wr_req.wdata),
		.events         (events),
		.ra_rdata       (ra_rdata),
		.rb_rdata       (rb_rdata),
		.bounds         (bounds),
		.mtvec          (mtvec),
		.mie            (mie),
		.meie           (meie),
		.soft_reset_req (soft_reset_req)
	);

	trap_guard u_trap_guard (
		.bounds      (bounds),
		.mie         (mie),
		.meie        (meie),
		.irq         (events.irq),
		.fetch_addr  (fetch_addr),
		.irq_pending (irq_pending),
		.dep_fault   (dep_fault)
	);

endmodule

/* rtl/trap_guard.sv */
// Combinational only; bounds are word aligned before comparing and the upper bound is exclusive
module trap_guard (
	input  fwrisc_pkg::prot_bounds_t bounds,
	input  logic                     mie,
	input  logic                     meie,
	input  logic                     irq,
	input  logic [31:0]              fetch_addr,
	output logic                     irq_pending,
	output logic                     dep_fault
);

	logic        window_active;
	logic [31:0] lo_aligned;
	logic [31:0] hi_aligned;
	logic        above_lo;
	logic        below_hi;

	// External interrupt needs both global and per-source enable
	assign irq_pending = irq && mie && meie;

	// Enable bit lives in bit 0 of the lower bound
	assign window_active = bounds.dep_lo[0];

	// Low bits carry the enable and lock flags
	assign lo_aligned = {bounds.dep_lo[31:2], 2'b00};
	assign hi_aligned = {bounds.dep_hi[31:2], 2'b00};

	assign above_lo = (fetch_addr >= lo_aligned);
	assign below_hi = (fetch_addr < hi_aligned);

	// Fetch inside the protected data region
	assign dep_fault = window_active && above_lo && below_hi;

endmodule

/* verification/tb_fwrisc_state_unit.sv */
// Needs the rtl folder on the include path; all checks are off while reset is high
`include "fwrisc_defines.svh"

module tb_fwrisc_state_unit;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_period = 40;
	localparam int n_gpr = 200;
	localparam int n_count = 80;
	localparam int n_irq = 150;
	// Reset, register fill, directed sections and the random loops
	localparam int test_cycles = 16 + 31 + 120 + n_gpr + n_count + n_irq;

	logic                    clock;
	logic                    reset;
	logic [4:0]              ra_raddr;
	fwrisc_pkg::rd_req_t     rb_req;
	fwrisc_pkg::wr_req_t     wr_req;
	fwrisc_pkg::core_event_t events;
	logic [31:0]             fetch_addr;
	logic [31:0]             ra_rdata;
	logic [31:0]             rb_rdata;
	logic                    csr_illegal;
	logic [31:0]             mtvec;
	logic                    irq_pending;
	logic                    dep_fault;
	logic                    soft_reset_req;

	// Shadow model of the architectural state
	logic [31:0] m_gpr [0:31];
	logic [63:0] m_cycle;
	logic [63:0] m_instret;
	logic        m_mie;
	logic        m_mpie;
	logic        m_meie;
	logic [31:0] m_mtvec;
	logic [31:0] m_mscratch;
	logic [31:0] m_dep_lo;
	logic [31:0] m_dep_hi;
	logic [31:0] exp_ra;
	logic [31:0] exp_rb;
	logic        exp_illegal;
	logic        exp_fault;

	integer seed = 32'h72d40141;
	// Slots 5..7 are the interrupt CSRs, 8..11 the counters, last one is unmapped
	logic [11:0] csr_nums [0:15] = '{12'hf11, 12'hf12, 12'hf13, 12'hf14, 12'h301, 12'h300,
		12'h304, 12'h344, 12'hb00, 12'hb80, 12'hb02, 12'hb82, 12'h7c0, 12'h7c1, 12'h7c2, 12'h123};
	logic [31:0] fetch_pts [0:6] = '{32'h0, 32'h0ffc, 32'h1000, 32'h1ffc, 32'h2000, 32'h2ffc,
		32'h3000};

	fwrisc_state_unit u_fwrisc_state_unit (.*);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	function automatic logic csr_known(input logic [11:0] num);
		case (num)
			12'hf11, 12'hf12, 12'hf13, 12'hf14, 12'h300, 12'h301, 12'h304, 12'h305, 12'h340,
			12'h344, 12'hb00, 12'hb80, 12'hb02, 12'hb82, 12'h7c0, 12'h7c1, 12'h7c2: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Expected read data for one port b request
	function automatic logic [31:0] model_read(input logic is_csr, input logic [11:0] num,
		input logic irq);
		if (!is_csr)
			return (num[4:0] == 5'd0) ? 32'd0 : m_gpr[num[4:0]];
		case (num)
			12'hf11: return `FWRISC_VENDORID;
			12'hf12: return `FWRISC_ARCHID;
			12'hf13: return `FWRISC_IMPID;
			12'hf14: return `FWRISC_HARTID;
			12'h301: return {2'b01, `FWRISC_ISA};
			12'h300: return {24'd0, m_mpie, 3'd0, m_mie, 3'd0};
			12'h304: return {20'd0, m_meie, 11'd0};
			12'h305: return m_mtvec;
			12'h340: return m_mscratch;
			12'h344: return {20'd0, irq, 11'd0};
			12'hb00: return m_cycle[31:0];
			12'hb80: return m_cycle[63:32];
			12'hb02: return m_instret[31:0];
			12'hb82: return m_instret[63:32];
			12'h7c0: return (`FWRISC_ENABLE_DEP != 0) ? m_dep_lo : 32'd0;
			12'h7c1: return (`FWRISC_ENABLE_DEP != 0) ? m_dep_hi : 32'd0;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic fault_expected(input logic [31:0] addr, input logic [31:0] lo,
		input logic [31:0] hi);
		return (`FWRISC_ENABLE_DEP != 0) && lo[0] && (addr >= (lo & ~32'd3))
			&& (addr < (hi & ~32'd3));
	endfunction

	function automatic fwrisc_pkg::wr_req_t csr_write(input logic [11:0] num, input logic [31:0] d);
		return {1'b1, 1'b1, num, d};
	endfunction

	function automatic fwrisc_pkg::rd_req_t csr_read(input logic [11:0] num);
		return {1'b1, num};
	endfunction

	// One clock of stimulus
	task automatic step(input fwrisc_pkg::wr_req_t w, input fwrisc_pkg::rd_req_t r,
		input logic [4:0] a, input fwrisc_pkg::core_event_t e);
		@(posedge clock);
		wr_req   <= w;
		rb_req   <= r;
		ra_raddr <= a;
		events   <= e;
	endtask

	task automatic sweep_fetch();
		integer k;
		for (k = 0; k < 13; k++) begin
			step('0, csr_read(k[0] ? 12'h7c1 : 12'h7c0), 5'd0, '0);
			if (k < 7)
				fetch_addr <= fetch_pts[k];
			else
				fetch_addr <= $random(seed) & 32'h0000_3ffc;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
		$display("Test failures found");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	always @(posedge clock) begin
		exp_ra <= (ra_raddr == 5'd0) ? 32'd0 : m_gpr[ra_raddr];
		exp_rb <= model_read(rb_req.is_csr, rb_req.num, events.irq);
		if (reset) begin
			m_cycle    <= '0;
			m_instret  <= '0;
			m_mie      <= 1'b1;
			m_mpie     <= 1'b0;
			m_meie     <= 1'b1;
			m_mtvec    <= '0;
			m_mscratch <= '0;
			m_dep_lo   <= '0;
			m_dep_hi   <= '0;
		end else begin
			m_cycle <= m_cycle + 64'd1;
			if (events.instr_complete)
				m_instret <= m_instret + 64'd1;
			if (events.trap) begin
				m_mpie <= m_mie;
				m_mie  <= 1'b0;
			end
			if (events.tret) begin
				m_mie  <= m_mpie;
				m_mpie <= 1'b0;
			end
			if (wr_req.wen && !wr_req.is_csr && (wr_req.num[4:0] != 5'd0))
				m_gpr[wr_req.num[4:0]] <= wr_req.wdata;
			if (wr_req.wen && wr_req.is_csr) begin
				case (wr_req.num)
					12'h300: begin
						m_mie  <= wr_req.wdata[3];
						m_mpie <= wr_req.wdata[7];
					end
					12'h304: m_meie <= wr_req.wdata[11];
					12'h305: m_mtvec <= wr_req.wdata;
					12'h340: m_mscratch <= wr_req.wdata;
					12'hb00: m_cycle <= {m_cycle[63:32], wr_req.wdata};
					12'hb80: m_cycle <= {wr_req.wdata, m_cycle[31:0]};
					12'hb02: m_instret <= {m_instret[63:32], wr_req.wdata};
					12'hb82: m_instret <= {wr_req.wdata, m_instret[31:0]};
					// A bound with bit 1 set stays put
					12'h7c0: if (!m_dep_lo[1])
						m_dep_lo <= wr_req.wdata;
					12'h7c1: if (!m_dep_hi[1])
						m_dep_hi <= wr_req.wdata;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		exp_illegal = (rb_req.is_csr && !csr_known(rb_req.num))
			|| (wr_req.wen && wr_req.is_csr && !csr_known(wr_req.num));
		exp_fault = fault_expected(fetch_addr, m_dep_lo, m_dep_hi);
	end

	assert property (@(posedge clock) disable iff (reset) ra_rdata == exp_ra)
		else report_mismatch("ra_rdata", $sampled(ra_rdata), $sampled(exp_ra));
	assert property (@(posedge clock) disable iff (reset) rb_rdata == exp_rb)
		else report_mismatch("rb_rdata", $sampled(rb_rdata), $sampled(exp_rb));
	assert property (@(posedge clock) disable iff (reset) csr_illegal == exp_illegal)
		else report_mismatch("csr_illegal", $sampled(csr_illegal), $sampled(exp_illegal));
	assert property (@(posedge clock) disable iff (reset) mtvec == m_mtvec)
		else report_mismatch("mtvec", $sampled(mtvec), $sampled(m_mtvec));
	assert property (@(posedge clock) disable iff (reset)
		irq_pending == (events.irq && m_mie && m_meie))
		else report_mismatch("irq_pending", $sampled(irq_pending),
			$sampled(events.irq && m_mie && m_meie));
	assert property (@(posedge clock) disable iff (reset) dep_fault == exp_fault)
		else report_mismatch("dep_fault", $sampled(dep_fault), $sampled(exp_fault));
	assert property (@(posedge clock) disable iff (reset)
		soft_reset_req == (wr_req.wen && wr_req.is_csr && wr_req.num == 12'h7c2))
		else report_mismatch("soft_reset_req", $sampled(soft_reset_req),
			$sampled(wr_req.wen && wr_req.is_csr && wr_req.num == 12'h7c2));

	initial begin
		#((test_cycles + 100) * clk_period);
		$display("Watchdog expired after %0d cycles without the test finishing", test_cycles + 100);
		$display("Test failures found");
		$fatal(1, "Stopped by the watchdog");
	end

	initial begin
		integer i;
		logic [31:0] r;
		logic [31:0] d;
		fwrisc_pkg::wr_req_t w;
		fwrisc_pkg::core_event_t ev;
		reset      = 1'b1;
		ra_raddr   = '0;
		rb_req     = '0;
		wr_req     = '0;
		events     = '0;
		fetch_addr = '0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		// Fill every general register, then random traffic on both ports
		for (i = 1; i < 32; i++) begin
			d = $random(seed);
			step({1'b1, 1'b0, 7'd0, i[4:0], d}, '0, 5'd0, '0);
		end
		for (i = 0; i < n_gpr; i++) begin
			r = $random(seed);
			d = $random(seed);
			step({r[5], 1'b0, 7'd0, r[4:0], d}, {1'b0, 7'd0, r[10:6]}, r[15:11], '0);
		end

		// Unmapped write, then read every CSR of interest
		step(csr_write(12'h123, 32'hffff_ffff), '0, 5'd0, '0);
		for (i = 0; i < 16; i++)
			step('0, csr_read(csr_nums[i]), 5'd0, '0);

		// Trap vector and scratch, read in the write cycle and after
		d = $random(seed);
		step(csr_write(12'h305, d), csr_read(12'h305), 5'd0, '0);
		r = $random(seed);
		step(csr_write(12'h340, r), csr_read(12'h305), 5'd0, '0);
		step('0, csr_read(12'h340), 5'd0, '0);

		// Counters close to a carry into the upper half
		step(csr_write(12'hb00, 32'hffff_ffc0), '0, 5'd0, '0);
		step(csr_write(12'hb82, 32'h0000_0005), '0, 5'd0, '0);
		for (i = 0; i < n_count; i++) begin
			r = $random(seed);
			ev = '0;
			ev.instr_complete = r[0];
			step('0, csr_read(csr_nums[8 + r[2:1]]), 5'd0, ev);
		end

		ev = '0;
		ev.trap = 1'b1;
		step('0, '0, 5'd0, ev);
		step('0, csr_read(12'h300), 5'd0, '0);
		ev = '0;
		ev.tret = 1'b1;
		step('0, csr_read(12'h300), 5'd0, ev);
		step('0, csr_read(12'h300), 5'd0, '0);

		// Random irq, trap, tret and enable writes
		for (i = 0; i < n_irq; i++) begin
			r = $random(seed);
			ev = '0;
			ev.irq = r[0];
			ev.trap = (r[3:1] == 3'd0);
			ev.tret = (r[3:1] == 3'd1);
			w = '0;
			if (r[6:4] == 3'd0)
				w = csr_write(12'h304, r);
			else if ((r[6:4] == 3'd1) && (r[3:2] != 2'd0))
				w = csr_write(12'h300, r);
			step(w, csr_read(csr_nums[5 + (r[8:7] % 3)]), 5'd0, ev);
		end

		// Window off, window on, then both bounds locked and rewritten
		sweep_fetch();
		step(csr_write(12'h7c1, 32'h0000_2000), '0, 5'd0, '0);
		step(csr_write(12'h7c0, 32'h0000_1001), '0, 5'd0, '0);
		sweep_fetch();
		step(csr_write(12'h7c0, 32'h0000_1003), '0, 5'd0, '0);
		step(csr_write(12'h7c0, 32'h0000_0000), '0, 5'd0, '0);
		step(csr_write(12'h7c1, 32'h0000_3002), '0, 5'd0, '0);
		step(csr_write(12'h7c1, 32'h0000_1000), '0, 5'd0, '0);
		sweep_fetch();

		step(csr_write(12'h7c2, 32'd1), '0, 5'd0, '0);
		step('0, '0, 5'd0, '0);
		step('0, '0, 5'd0, '0);
		$display("All tests passed!");
		$finish;
	end

endmodule
